/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_fixed_silu
FILELIST  = fixed_silu.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

/* fixed_silu.f */
+incdir+.
silu_num_pkg.sv
silu_stream_pkg.sv
silu_input_fifo.sv
lane_roller.sv
silu_approx.sv
silu_output_slice.sv
fixed_silu.sv
fixed_silu_assert.sv
tb_fixed_silu.sv

/* fixed_silu.sv */
`include "silu_defs.svh"

module fixed_silu (
  input  logic                       clk,
  input  logic                       reset,
  input  silu_stream_pkg::in_word_t  in_word,
  input  logic                       in_valid,
  output logic                       in_ready,
  output silu_stream_pkg::out_beat_t out_beat,
  output logic                       out_valid,
  input  logic                       out_ready
);
  import silu_stream_pkg::*;

  in_word_t  fifo_word;
  logic      fifo_valid;
  logic      fifo_ready;
  out_beat_t roll_beat;
  logic      roll_valid;
  logic      roll_ready;
  out_beat_t act_beat;
  logic      act_valid;
  logic      act_ready;

  silu_input_fifo #(
    .DEPTH(`SILU_FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_word   (in_word),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .fifo_word (fifo_word),
    .fifo_valid(fifo_valid),
    .fifo_ready(fifo_ready)
  );

  lane_roller u_roller (
    .clk       (clk),
    .reset     (reset),
    .fifo_word (fifo_word),
    .fifo_valid(fifo_valid),
    .fifo_ready(fifo_ready),
    .roll_beat (roll_beat),
    .roll_valid(roll_valid),
    .roll_ready(roll_ready)
  );

  silu_approx u_approx (
    .clk       (clk),
    .reset     (reset),
    .roll_beat (roll_beat),
    .roll_valid(roll_valid),
    .roll_ready(roll_ready),
    .act_beat  (act_beat),
    .act_valid (act_valid),
    .act_ready (act_ready)
  );

  silu_output_slice u_slice (
    .clk      (clk),
    .reset    (reset),
    .act_beat (act_beat),
    .act_valid(act_valid),
    .act_ready(act_ready),
    .out_beat (out_beat),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

endmodule

/* fixed_silu_assert.sv */
module fixed_silu_assert (
  input logic                       clk,
  input logic                       reset,
  input silu_stream_pkg::in_word_t  in_word,
  input logic                       in_valid,
  input logic                       in_ready,
  input silu_stream_pkg::out_beat_t out_beat,
  input logic                       out_valid,
  input logic                       out_ready,
  input logic                       fifo_valid,
  input logic                       roll_valid,
  input logic                       act_valid
);

  out_held: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("out_valid or out_beat changed while out_ready was low");

  in_held: assert property (@(posedge clk) disable iff (reset)
    in_valid && !in_ready |=> in_valid && $stable(in_word))
    else $error("in_valid or in_word changed while in_ready was low");

  // Every stage must come out of reset empty.
  valids_clear: assert property (@(posedge clk)
    reset |=> !(fifo_valid || roll_valid || act_valid || out_valid))
    else $error("a valid was high in the cycle after reset");

endmodule

bind fixed_silu fixed_silu_assert u_assert (
  .clk(clk), .reset(reset), .in_word(in_word), .in_valid(in_valid), .in_ready(in_ready),
  .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
  .fifo_valid(fifo_valid), .roll_valid(roll_valid), .act_valid(act_valid)
);

/* lane_roller.sv */
`include "silu_defs.svh"

module lane_roller (
  input  logic                       clk,
  input  logic                       reset,
  input  silu_stream_pkg::in_word_t  fifo_word,
  input  logic                       fifo_valid,
  output logic                       fifo_ready,
  output silu_stream_pkg::out_beat_t roll_beat,
  output logic                       roll_valid,
  input  logic                       roll_ready
);
  import silu_stream_pkg::*;

  localparam int NUM_BEATS = `SILU_IN_LANES / `SILU_OUT_LANES;
  localparam int IDX_W     = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;

  typedef enum logic {
    state_empty,
    state_holding
  } roll_state_t;

  roll_state_t      state;
  in_word_t         word_q;
  logic [IDX_W-1:0] beat_idx;
  logic             last_beat;
  logic             beat_xfer;
  logic             load;

  assign roll_valid = (state == state_holding);
  assign last_beat  = (beat_idx == IDX_W'(NUM_BEATS - 1));
  assign beat_xfer  = roll_valid && roll_ready;
  // A new word may replace the old one on the edge its last beat leaves.
  assign fifo_ready = (state == state_empty) || (beat_xfer && last_beat);
  assign load       = fifo_valid && fifo_ready;

  always_comb begin
    for (int j = 0; j < `SILU_OUT_LANES; j++) begin
      roll_beat.lanes[j] = word_q.lanes[int'(beat_idx) * `SILU_OUT_LANES + j];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= state_empty;
      beat_idx <= '0;
    end else if (load) begin
      state    <= state_holding;
      beat_idx <= '0;
    end else if (beat_xfer) begin
      if (last_beat) begin
        state    <= state_empty;
        beat_idx <= '0;
      end else begin
        beat_idx <= beat_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      word_q <= fifo_word;
    end
  end

endmodule

/* silu_approx.sv */
`include "silu_defs.svh"

module silu_approx (
  input  logic                       clk,
  input  logic                       reset,
  input  silu_stream_pkg::out_beat_t roll_beat,
  input  logic                       roll_valid,
  output logic                       roll_ready,
  output silu_stream_pkg::out_beat_t act_beat,
  output logic                       act_valid,
  input  logic                       act_ready
);
  import silu_num_pkg::*;
  import silu_stream_pkg::*;

  localparam int GATE_SHIFT = 2;
  localparam int GATE_HALF  = 1 << (`SILU_FRAC_BITS - 1);
  localparam int GATE_ONE   = 1 << `SILU_FRAC_BITS;

  out_beat_t result;

  // Hard sigmoid gate x/4 + 0.5 clamped to [0, 1], then x * gate.
  function automatic act_t silu_lane(input act_t x);
    int    g_sum;
    gate_t g;
    prod_t p;
    g_sum = (x >>> GATE_SHIFT) + GATE_HALF;
    if (g_sum < 0) begin
      g = '0;
    end else if (g_sum > GATE_ONE) begin
      g = gate_t'(GATE_ONE);
    end else begin
      g = gate_t'(g_sum);
    end
    p = prod_t'(x) * prod_t'({1'b0, g});
    return act_t'(p >>> `SILU_FRAC_BITS);  // Floor shift, the result always fits.
  endfunction

  always_comb begin
    for (int i = 0; i < `SILU_OUT_LANES; i++) begin
      result.lanes[i] = silu_lane(roll_beat.lanes[i]);
    end
  end

  assign roll_ready = !act_valid || act_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      act_valid <= 1'b0;
    end else if (roll_ready) begin
      act_valid <= roll_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (roll_valid && roll_ready) begin
      act_beat <= result;
    end
  end

endmodule

/* silu_defs.svh */
`ifndef SILU_DEFS_SVH
`define SILU_DEFS_SVH

// Bit width of one Q4.4 activation.
`define SILU_DATA_WIDTH 8

// Fraction bits of an activation, so 16 stands for 1.0.
`define SILU_FRAC_BITS 4

// Lanes per input word.
`define SILU_IN_LANES 4

// Lanes per output beat. SILU_IN_LANES must be a multiple of this.
`define SILU_OUT_LANES 2

// Input FIFO depth in whole words.
`define SILU_FIFO_DEPTH 4

`endif

/* silu_input_fifo.sv */
`include "silu_defs.svh"

module silu_input_fifo #(
  parameter int DEPTH = `SILU_FIFO_DEPTH
) (
  input  logic                      clk,
  input  logic                      reset,
  input  silu_stream_pkg::in_word_t in_word,
  input  logic                      in_valid,
  output logic                      in_ready,
  output silu_stream_pkg::in_word_t fifo_word,
  output logic                      fifo_valid,
  input  logic                      fifo_ready
);
  import silu_stream_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  in_word_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Wrap explicitly so depths that are not a power of two still work.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign in_ready   = (count != CNT_W'(DEPTH));  // Low only while every entry holds a word.
  assign fifo_valid = (count != '0);
  assign fifo_word  = mem[rd_ptr];
  assign push       = in_valid && in_ready;
  assign pop        = fifo_valid && fifo_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither leaves occupancy as it was.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_word;
    end
  end

endmodule

/* silu_num_pkg.sv */
`include "silu_defs.svh"

package silu_num_pkg;

  // Signed Q4.4 activation.
  typedef logic signed [`SILU_DATA_WIDTH-1:0] act_t;

  // Gate from 0 to 1.0, which needs one bit above the fraction.
  typedef logic [`SILU_FRAC_BITS:0] gate_t;

  // Activation times gate before the fraction shift.
  typedef logic signed [`SILU_DATA_WIDTH+`SILU_FRAC_BITS:0] prod_t;

endpackage

/* silu_output_slice.sv */
module silu_output_slice (
  input  logic                       clk,
  input  logic                       reset,
  input  silu_stream_pkg::out_beat_t act_beat,
  input  logic                       act_valid,
  output logic                       act_ready,
  output silu_stream_pkg::out_beat_t out_beat,
  output logic                       out_valid,
  input  logic                       out_ready
);
  import silu_stream_pkg::*;

  out_beat_t spare_beat;
  logic      spare_valid;
  logic      act_xfer;
  logic      main_free;

  assign act_ready = !spare_valid;  // Straight from a register.
  assign act_xfer  = act_valid && act_ready;
  assign main_free = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid   <= 1'b0;
      spare_valid <= 1'b0;
    end else begin
      if (main_free) begin
        out_valid <= spare_valid || act_xfer;
      end
      if (act_xfer && !main_free) begin
        spare_valid <= 1'b1;  // Main is stalled, so the spare catches the beat.
      end else if (main_free) begin
        spare_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      out_beat <= spare_valid ? spare_beat : act_beat;
    end
    if (act_xfer && !main_free) begin
      spare_beat <= act_beat;
    end
  end

endmodule

/* silu_stream_pkg.sv */
`include "silu_defs.svh"

package silu_stream_pkg;

  // Lane 0 sits in the low bits of the word.
  typedef struct packed {
    silu_num_pkg::act_t [`SILU_IN_LANES-1:0] lanes;
  } in_word_t;

  // One beat leaving the lane roller and the output port.
  typedef struct packed {
    silu_num_pkg::act_t [`SILU_OUT_LANES-1:0] lanes;
  } out_beat_t;

endpackage

/* tb_fixed_silu.sv */
`include "silu_defs.svh"

module tb_fixed_silu;
  import silu_stream_pkg::*;

  localparam int SWEEP_WORDS = 64;
  localparam int RAND_WORDS  = 300;
  localparam int BP_WORDS    = 100;
  localparam int FLUSH_WORDS = 3;
  localparam int AFTER_WORDS = 20;
  localparam int TOTAL_WORDS = SWEEP_WORDS + 2 + RAND_WORDS + BP_WORDS + FLUSH_WORDS + AFTER_WORDS;

  logic       clk;
  logic       reset;
  in_word_t   in_word;
  logic       in_valid;
  logic       in_ready;
  out_beat_t  out_beat;
  logic       out_valid;
  logic       out_ready;
  logic [1:0] ready_mode;  // 0 always ready, 1 random stalls, 2 held low.
  integer     seed = 32'h77c5_2fe3;
  integer     ready_seed = 32'h77c5_2fe3;
  logic [7:0] exp_q[$];  // Input lanes whose outputs are still due.
  int         full_cycles;
  int         full_mark;

  fixed_silu UUT (
    .clk(clk), .reset(reset), .in_word(in_word), .in_valid(in_valid), .in_ready(in_ready),
    .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
  );

  // Gate is x/4 + 0.5 clamped to [0, 1.0], result is floor(x * gate / 16).
  function automatic logic [7:0] silu_ref(input logic signed [7:0] x);
    int xi;
    int g;
    xi = x;
    g = (xi >>> 2) + 8;
    if (g < 0) begin
      g = 0;
    end else if (g > 16) begin
      g = 16;
    end
    return 8'((xi * g) >>> 4);
  endfunction

  task automatic abort_run;
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // Called right after a rising edge; returns on the edge that transfers the word.
  task automatic send_word(input logic [31:0] word, input int gap);
    if (gap > 0) begin
      in_valid <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    in_word  <= word;
    in_valid <= 1'b1;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
  endtask

  task automatic drain_outputs;
    in_valid <= 1'b0;
    @(posedge clk);
    // Each beat takes two lanes, so an empty queue means two beats per word came out.
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    case (ready_mode)
      2'd1:    out_ready <= ({$random(ready_seed)} % 10) >= 4;  // About 40 percent stalls.
      2'd2:    out_ready <= 1'b0;
      default: out_ready <= 1'b1;
    endcase
  end

  always @(posedge clk) begin : scoreboard
    logic [7:0] lane_in;
    if (reset) begin
      exp_q.delete();
    end else begin
      if (in_valid && in_ready) begin
        for (int i = 0; i < `SILU_IN_LANES; i++) begin
          exp_q.push_back(in_word.lanes[i]);
        end
      end
      if (!in_ready) begin
        full_cycles++;
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() < `SILU_OUT_LANES) begin
          $display("An output beat arrived with no input lanes left to match it.");
          abort_run();
        end
        for (int j = 0; j < `SILU_OUT_LANES; j++) begin
          lane_in = exp_q.pop_front();
          check_value($sformatf("out_beat.lanes[%0d]", j), {24'h0, out_beat.lanes[j]},
                      {24'h0, silu_ref(lane_in)});
        end
      end
    end
  end

  initial begin
    repeat (TOTAL_WORDS * 40 + 200) @(posedge clk);
    $display("Timeout: the DUT stopped delivering outputs before the tests finished.");
    abort_run();
  end

  initial begin
    reset       = 1'b1;
    in_word     = '0;
    in_valid    = 1'b0;
    out_ready   = 1'b1;
    ready_mode  = 2'd0;
    full_cycles = 0;
    check_value("silu_ref(-128)", {24'h0, silu_ref(-8'sd128)}, 32'h00);
    check_value("silu_ref(127)", {24'h0, silu_ref(8'sd127)}, 32'h7f);
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < SWEEP_WORDS; i++) begin
      send_word({8'(4 * i + 3), 8'(4 * i + 2), 8'(4 * i + 1), 8'(4 * i)}, 0);
    end
    send_word({8'hff, 8'hf8, 8'hf7, 8'h80}, 0);  // -1, -8, -9, -128 from lane 3 down.
    send_word({8'h7f, 8'h08, 8'h07, 8'h00}, 0);
    drain_outputs();
    for (int i = 0; i < RAND_WORDS; i++) begin
      send_word($random(seed), {$random(seed)} % 4);
    end
    drain_outputs();
    ready_mode <= 2'd1;
    full_mark = full_cycles;
    for (int i = 0; i < BP_WORDS; i++) begin
      send_word($random(seed), 0);
    end
    drain_outputs();
    check_value("in_ready_low_seen", {31'h0, full_cycles > full_mark}, 32'h1);
    ready_mode <= 2'd2;
    for (int i = 0; i < FLUSH_WORDS; i++) begin
      send_word($random(seed), 0);
    end
    in_valid <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset      <= 1'b0;
    ready_mode <= 2'd0;
    check_value("out_valid", {31'h0, out_valid}, 32'h0);
    check_value("in_ready", {31'h0, in_ready}, 32'h1);
    for (int i = 0; i < AFTER_WORDS; i++) begin
      send_word($random(seed), {$random(seed)} % 3);
    end
    drain_outputs();
    $display("All tests passed");
    $finish;
  end

endmodule
